// File: common/flash_pkg.sv
package flash_pkg;

    // Host side operations
    typedef enum logic [1:0] {
        OP_READ = 2'd0,
        OP_RDSR = 2'd1,
        OP_RDID = 2'd2
    } flash_op_e;

    // SPI NOR opcodes
    localparam logic [7:0] CMD_READ = 8'h03;   // Read data bytes
    localparam logic [7:0] CMD_RDSR = 8'h05;   // Read status register
    localparam logic [7:0] CMD_RDID = 8'h9F;   // Read JEDEC ID

    // One frame as seen by the shift engine
    typedef struct packed {
        flash_op_e   op;
        logic [7:0]  cmd;
        logic [23:0] addr;
        logic        has_addr;   // Address phase present
    } spi_xfer_t;

    // Finished frame back from the engine
    typedef struct packed {
        flash_op_e  op;
        logic [7:0] data;
    } spi_rx_t;

    // Engine phases, IDLE is shared with the decode stage
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        CMD    = 3'd1,
        ADDR   = 3'd2,
        DATA   = 3'd3,
        FINISH = 3'd4
    } engine_state_e;

endpackage

// File: hw/flash_cmd_decode.sv
`timescale 1ns/100ps

module flash_cmd_decode (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic                 start,
    input  flash_pkg::flash_op_e op,
    input  logic [23:0]          addr,
    input  logic                 busy,
    output flash_pkg::spi_xfer_t xfer,
    output logic                 xfer_go
);

    flash_pkg::engine_state_e dec_state;
    logic                     op_ok;
    logic [7:0]               cmd_byte;
    logic                     accept;

    // Opcode lookup
    always_comb begin
        op_ok    = 1'b1;
        cmd_byte = 8'h00;
        case (op)
            flash_pkg::OP_READ: cmd_byte = flash_pkg::CMD_READ;
            flash_pkg::OP_RDSR: cmd_byte = flash_pkg::CMD_RDSR;
            flash_pkg::OP_RDID: cmd_byte = flash_pkg::CMD_RDID;
            default:            op_ok    = 1'b0;   // Unknown op, no frame
        endcase
    end

    // Engine raises busy one cycle after xfer_go, so the issue cycle
    // itself has to block a new start
    assign accept = start && !busy && op_ok && (dec_state == flash_pkg::IDLE);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            dec_state <= flash_pkg::IDLE;
        end else if (accept) begin
            dec_state <= flash_pkg::CMD;
        end else begin
            dec_state <= flash_pkg::IDLE;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept) begin
            xfer.op       <= op;
            xfer.cmd      <= cmd_byte;
            xfer.has_addr <= (op == flash_pkg::OP_READ);
            if (op == flash_pkg::OP_READ) begin
                xfer.addr <= addr;
            end else begin
                xfer.addr <= 24'h000000;
            end
        end
    end

    assign xfer_go = (dec_state == flash_pkg::CMD);   // One cycle after accept

endmodule

// File: spi_engine/spi_shift_engine.sv
`timescale 1ns/100ps

module spi_shift_engine #(
    parameter int HALF_CYCLES = 5
) (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  flash_pkg::spi_xfer_t xfer,
    input  logic                 xfer_go,
    input  logic                 spi_miso,
    output logic                 spi_sck,
    output logic                 spi_cs_n,
    output logic                 spi_mosi,
    output logic                 busy,
    output flash_pkg::spi_rx_t   rx,
    output logic                 rx_valid
);

    localparam int CNT_W = (HALF_CYCLES > 1) ? $clog2(HALF_CYCLES) : 1;

    flash_pkg::engine_state_e state;
    flash_pkg::engine_state_e next_state;
    logic [CNT_W-1:0]         half_cnt;
    logic [4:0]               bit_cnt;
    logic                     bit_last;
    logic                     half_end;
    logic                     in_frame;
    logic                     sck_rise;
    logic                     sck_fall;
    logic [31:0]              tx_shift;
    logic [7:0]               rx_shift;
    flash_pkg::flash_op_e     cur_op;
    logic                     cur_has_addr;

    assign in_frame = (state == flash_pkg::CMD) || (state == flash_pkg::ADDR) ||
                      (state == flash_pkg::DATA);
    assign half_end = (half_cnt == CNT_W'(HALF_CYCLES - 1));
    assign sck_rise = in_frame && half_end && !spi_sck;
    assign sck_fall = in_frame && half_end && spi_sck;

    // Phase length and successor
    always_comb begin
        next_state = state;
        bit_last   = 1'b0;
        case (state)
            flash_pkg::CMD: begin
                bit_last   = (bit_cnt == 5'd7);
                next_state = cur_has_addr ? flash_pkg::ADDR : flash_pkg::DATA;
            end
            flash_pkg::ADDR: begin
                bit_last   = (bit_cnt == 5'd23);
                next_state = flash_pkg::DATA;
            end
            flash_pkg::DATA: begin
                bit_last   = (bit_cnt == 5'd7);
                next_state = flash_pkg::FINISH;
            end
            default: ;
        endcase
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= flash_pkg::IDLE;
            half_cnt <= '0;
            bit_cnt  <= 5'd0;
            spi_sck  <= 1'b0;
            spi_cs_n <= 1'b1;
            spi_mosi <= 1'b0;
            busy     <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (xfer_go) begin
                state    <= flash_pkg::CMD;
                half_cnt <= '0;
                bit_cnt  <= 5'd0;
                spi_sck  <= 1'b0;
                spi_cs_n <= 1'b0;
                spi_mosi <= xfer.cmd[7];   // Opcode MSB first
                busy     <= 1'b1;
            end else begin
                case (state)
                    flash_pkg::IDLE: ;
                    flash_pkg::CMD, flash_pkg::ADDR, flash_pkg::DATA: begin
                        if (half_end) begin
                            half_cnt <= '0;
                            spi_sck  <= ~spi_sck;
                            if (spi_sck) begin
                                // Falling edge ends the bit
                                spi_mosi <= tx_shift[30];
                                if (bit_last) begin
                                    bit_cnt <= 5'd0;
                                    state   <= next_state;
                                end else begin
                                    bit_cnt <= bit_cnt + 5'd1;
                                end
                            end
                        end else begin
                            half_cnt <= half_cnt + 1'b1;
                        end
                    end
                    flash_pkg::FINISH: begin
                        spi_cs_n <= 1'b1;
                        spi_mosi <= 1'b0;
                        busy     <= 1'b0;
                        rx_valid <= 1'b1;
                        state    <= flash_pkg::IDLE;
                    end
                    default: state <= flash_pkg::IDLE;
                endcase
            end
        end
    end

    // Zero fill keeps MOSI low after the last transmitted bit
    always_ff @(posedge sys_clk) begin
        if (xfer_go) begin
            cur_op       <= xfer.op;
            cur_has_addr <= xfer.has_addr;
            if (xfer.has_addr) begin
                tx_shift <= {xfer.cmd, xfer.addr};
            end else begin
                tx_shift <= {xfer.cmd, 24'h000000};
            end
        end else if (sck_fall) begin
            tx_shift <= {tx_shift[30:0], 1'b0};
        end
    end

    always_ff @(posedge sys_clk) begin
        if (sck_rise && (state == flash_pkg::DATA)) begin
            rx_shift <= {rx_shift[6:0], spi_miso};   // Sample as SCK goes high
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == flash_pkg::FINISH) begin
            rx.op   <= cur_op;
            rx.data <= rx_shift;
        end
    end

endmodule

// File: hw/flash_result.sv
`timescale 1ns/100ps

module flash_result (
    input  logic               sys_clk,
    input  logic               sys_rst_n,
    input  flash_pkg::spi_rx_t rx,
    input  logic               rx_valid,
    output logic [7:0]         rd_data,
    output logic               done,
    output logic               wip_clear
);

    localparam int WIP_BIT = 0;   // Write in progress flag in the status byte

    logic status_idle;

    // Flash reports no write or erase in progress
    assign status_idle = (rx.op == flash_pkg::OP_RDSR) && !rx.data[WIP_BIT];

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rd_data <= 8'h00;
        end else if (rx_valid) begin
            rd_data <= rx.data;   // Held until the next frame
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            done <= 1'b0;
        end else begin
            done <= rx_valid;
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wip_clear <= 1'b0;
        end else begin
            wip_clear <= rx_valid && status_idle;   // Same cycle as done
        end
    end

endmodule

// File: hw/flash_ctrl_top.sv
`timescale 1ns/100ps

module flash_ctrl_top #(
    parameter int HALF_CYCLES = 5   // SCK half period in sys_clk cycles
) (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic                 start,
    input  flash_pkg::flash_op_e op,
    input  logic [23:0]          addr,
    input  logic                 spi_miso,
    output logic                 spi_sck,
    output logic                 spi_cs_n,
    output logic                 spi_mosi,
    output logic                 busy,
    output logic                 done,
    output logic [7:0]           rd_data,
    output logic                 wip_clear
);

    flash_pkg::spi_xfer_t xfer;
    logic                 xfer_go;
    flash_pkg::spi_rx_t   rx;
    logic                 rx_valid;

    flash_cmd_decode u_decode (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .start     (start),
        .op        (op),
        .addr      (addr),
        .busy      (busy),
        .xfer      (xfer),
        .xfer_go   (xfer_go)
    );

    spi_shift_engine #(
        .HALF_CYCLES (HALF_CYCLES)
    ) u_engine (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .xfer      (xfer),
        .xfer_go   (xfer_go),
        .spi_miso  (spi_miso),
        .spi_sck   (spi_sck),
        .spi_cs_n  (spi_cs_n),
        .spi_mosi  (spi_mosi),
        .busy      (busy),
        .rx        (rx),
        .rx_valid  (rx_valid)
    );

    flash_result u_result (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .rx        (rx),
        .rx_valid  (rx_valid),
        .rd_data   (rd_data),
        .done      (done),
        .wip_clear (wip_clear)
    );

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter real HALF_PERIOD  = 4.0,   // 8 ns clock
    parameter int  RESET_CYCLES = 2
) (
    output logic sys_clk,
    output logic sys_rst_n
);

    initial begin
        sys_clk = 1'b0;
        forever #(HALF_PERIOD) sys_clk = ~sys_clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        sys_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst_n = 1'b1;
    end

endmodule

// File: tb/spi_flash_model.sv
`timescale 1ns/100ps

module spi_flash_model #(
    parameter logic [7:0] ID_BYTE = 8'hEF
) (
    input  logic        spi_sck,
    input  logic        spi_cs_n,
    input  logic        spi_mosi,
    input  logic [7:0]  status,
    output logic        spi_miso,
    output logic [7:0]  seen_cmd,
    output logic [23:0] seen_addr,
    output int          rise_count,
    output int          frame_count
);

    logic [31:0] rx_bits;
    logic [7:0]  out_byte;
    int          hdr_len;

    // Memory contents: address bytes folded by XOR
    function automatic logic [7:0] mem_byte(input logic [23:0] a);
        return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5A;
    endfunction

    initial begin
        spi_miso    = 1'b0;
        seen_cmd    = 8'h00;
        seen_addr   = 24'h000000;
        rise_count  = 0;
        frame_count = 0;
        rx_bits     = 32'h0;
        out_byte    = 8'h00;
        hdr_len     = 8;
    end

    always @(negedge spi_cs_n) begin
        frame_count = frame_count + 1;
        rise_count  = 0;
        seen_cmd    = 8'h00;
        seen_addr   = 24'h000000;
        rx_bits     = 32'h0;
        spi_miso    = 1'b0;
    end

    // Mode 0, MOSI taken on the rising edge
    always @(posedge spi_sck) begin
        if (!spi_cs_n) begin
            rx_bits    = {rx_bits[30:0], spi_mosi};
            rise_count = rise_count + 1;
            if (rise_count == 8) begin
                seen_cmd = rx_bits[7:0];
            end
            if ((rise_count == 32) && (seen_cmd == 8'h03)) begin
                seen_addr = rx_bits[23:0];
            end
        end
    end

    // MISO moves on the falling edge, ahead of the next rise
    always @(negedge spi_sck) begin
        if (!spi_cs_n) begin
            hdr_len = (seen_cmd == 8'h03) ? 32 : 8;
            if (rise_count == hdr_len) begin
                case (seen_cmd)
                    8'h03:   out_byte = mem_byte(seen_addr);
                    8'h05:   out_byte = status;
                    8'h9F:   out_byte = ID_BYTE;
                    default: out_byte = 8'h00;
                endcase
            end
            if ((rise_count >= hdr_len) && (rise_count < hdr_len + 8)) begin
                spi_miso = out_byte[7 - (rise_count - hdr_len)];
            end else begin
                spi_miso = 1'b0;
            end
        end
    end

endmodule

// File: tb/tb_flash_ctrl.sv
`timescale 1ns/100ps

module tb_flash_ctrl;

    localparam int DONE_TIMEOUT = 2000;
    localparam int IDLE_CYCLES  = 24;   // Window for a stray second frame

    logic                 sys_clk;
    logic                 sys_rst_n;
    logic                 start;
    flash_pkg::flash_op_e op;
    logic [23:0]          addr;
    logic                 spi_miso;
    logic                 spi_sck;
    logic                 spi_cs_n;
    logic                 spi_mosi;
    logic                 busy;
    logic                 done;
    logic [7:0]           rd_data;
    logic                 wip_clear;
    logic [7:0]           model_status;
    logic [7:0]           seen_cmd;
    logic [23:0]          seen_addr;
    int                   rise_count;
    int                   frame_count;

    int done_count     = 0;
    int check_count    = 0;
    int mismatch_count = 0;
    int other_count    = 0;
    logic stop_run     = 1'b0;

    tb_clk_gen u_clk (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n)
    );

    flash_ctrl_top #(
        .HALF_CYCLES (5)
    ) dut (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .start     (start),
        .op        (op),
        .addr      (addr),
        .spi_miso  (spi_miso),
        .spi_sck   (spi_sck),
        .spi_cs_n  (spi_cs_n),
        .spi_mosi  (spi_mosi),
        .busy      (busy),
        .done      (done),
        .rd_data   (rd_data),
        .wip_clear (wip_clear)
    );

    spi_flash_model u_flash (
        .spi_sck     (spi_sck),
        .spi_cs_n    (spi_cs_n),
        .spi_mosi    (spi_mosi),
        .status      (model_status),
        .spi_miso    (spi_miso),
        .seen_cmd    (seen_cmd),
        .seen_addr   (seen_addr),
        .rise_count  (rise_count),
        .frame_count (frame_count)
    );

    always @(posedge sys_clk) begin
        if (done) begin
            done_count <= done_count + 1;
        end
    end

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count = check_count + 1;
        if (expected !== actual) begin
            mismatch_count = mismatch_count + 1;
            $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic decode_op_name(input string name, output flash_pkg::flash_op_e code,
                                  output logic ok);
        ok   = 1'b1;
        code = flash_pkg::OP_READ;
        if (name == "READ") begin
            code = flash_pkg::OP_READ;
        end else if (name == "RDSR") begin
            code = flash_pkg::OP_RDSR;
        end else if (name == "RDID") begin
            code = flash_pkg::OP_RDID;
        end else begin
            ok = 1'b0;
        end
    endtask

    task automatic pulse_start(input flash_pkg::flash_op_e p_op, input logic [23:0] p_addr);
        start = 1'b1;
        op    = p_op;
        addr  = p_addr;
        @(negedge sys_clk);
        start = 1'b0;
    endtask

    task automatic run_test(input string test_name, input flash_pkg::flash_op_e t_op,
                            input logic [23:0] t_addr, input logic [7:0] t_status,
                            input logic [7:0] exp_data, input logic exp_wip,
                            input int restart);
        int                   frames_before;
        int                   dones_before;
        int                   wait_cycles;
        logic                 got_done;
        logic                 got_wip;
        logic [7:0]           got_data;
        logic [7:0]           exp_cmd;
        logic [23:0]          exp_addr;
        int                   exp_rises;
        flash_pkg::flash_op_e other_op;
        model_status  = t_status;
        frames_before = frame_count;
        dones_before  = done_count;
        got_done      = 1'b0;
        got_wip       = 1'b0;
        got_data      = 8'h00;
        wait_cycles   = 0;
        @(negedge sys_clk);
        pulse_start(t_op, t_addr);
        if (restart > 0) begin
            // Other op, so an accepted restart changes the result
            other_op = (t_op == flash_pkg::OP_RDID) ? flash_pkg::OP_RDSR
                                                    : flash_pkg::OP_RDID;
            repeat (restart - 1) @(negedge sys_clk);
            pulse_start(other_op, ~t_addr);   // Must be dropped
        end
        while (!got_done && (wait_cycles < DONE_TIMEOUT)) begin
            if (done) begin
                got_done = 1'b1;
                got_wip  = wip_clear;
                got_data = rd_data;
            end else begin
                @(negedge sys_clk);
                wait_cycles = wait_cycles + 1;
            end
        end
        if (!got_done) begin
            $display("ERROR: test %s got no done within %0d cycles", test_name, DONE_TIMEOUT);
            other_count = other_count + 1;
            stop_run    = 1'b1;
        end else begin
            repeat (IDLE_CYCLES) @(negedge sys_clk);
            case (t_op)
                flash_pkg::OP_READ: exp_cmd = 8'h03;
                flash_pkg::OP_RDSR: exp_cmd = 8'h05;
                default:            exp_cmd = 8'h9F;
            endcase
            exp_addr  = (t_op == flash_pkg::OP_READ) ? t_addr : 24'h000000;
            exp_rises = (t_op == flash_pkg::OP_READ) ? 40 : 16;
            check_value(test_name, "rd_data", 32'(exp_data), 32'(got_data));
            check_value(test_name, "rd_data held", 32'(exp_data), 32'(rd_data));
            check_value(test_name, "wip_clear", 32'(exp_wip), 32'(got_wip));
            check_value(test_name, "opcode", 32'(exp_cmd), 32'(seen_cmd));
            check_value(test_name, "address", 32'(exp_addr), 32'(seen_addr));
            check_value(test_name, "sck rises", 32'(exp_rises), 32'(rise_count));
            check_value(test_name, "frames", 32'd1, 32'(frame_count - frames_before));
            check_value(test_name, "done pulses", 32'd1, 32'(done_count - dones_before));
            check_value(test_name, "cs_n idle", 32'd1, 32'(spi_cs_n));
            check_value(test_name, "busy idle", 32'd0, 32'(busy));
        end
    endtask

    initial begin
        int                   fd;
        int                   n;
        int                   wait_cycles;
        int                   t_restart;
        string                test_name;
        string                op_name;
        string                rest;
        logic [23:0]          t_addr;
        logic [7:0]           t_status;
        logic [7:0]           t_data;
        logic [7:0]           t_wip;
        logic                 op_ok;
        flash_pkg::flash_op_e t_op;

        start        = 1'b0;
        op           = flash_pkg::OP_READ;
        addr         = 24'h000000;
        model_status = 8'h00;
        wait_cycles  = 0;

        while ((sys_rst_n !== 1'b1) && (wait_cycles < 20)) begin
            @(negedge sys_clk);
            wait_cycles = wait_cycles + 1;
        end
        if (sys_rst_n !== 1'b1) begin
            $display("ERROR: reset was never released");
            other_count = other_count + 1;
            stop_run    = 1'b1;
        end else begin
            @(negedge sys_clk);
            check_value("reset", "cs_n", 32'd1, 32'(spi_cs_n));
            check_value("reset", "sck", 32'd0, 32'(spi_sck));
            check_value("reset", "busy", 32'd0, 32'(busy));
            check_value("reset", "done", 32'd0, 32'(done));
            check_value("reset", "wip_clear", 32'd0, 32'(wip_clear));
            check_value("reset", "rd_data", 32'd0, 32'(rd_data));
        end

        fd = $fopen("tb/flash_tests.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open tb/flash_tests.txt");
            other_count = other_count + 1;
            stop_run    = 1'b1;
        end
        while (!stop_run) begin
            n = $fscanf(fd, "%s", test_name);
            if (n != 1) begin
                stop_run = 1'b1;   // End of file
            end else if (test_name.substr(0, 0) == "#") begin
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%s %h %h %h %h %d", op_name, t_addr, t_status, t_data,
                            t_wip, t_restart);
                decode_op_name(op_name, t_op, op_ok);
                if ((n != 6) || !op_ok) begin
                    $display("ERROR: test %s has a malformed line in the tests file", test_name);
                    other_count = other_count + 1;
                    stop_run    = 1'b1;
                end else begin
                    run_test(test_name, t_op, t_addr, t_status, t_data, t_wip[0], t_restart);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                 check_count, mismatch_count, other_count);
        if ((mismatch_count == 0) && (other_count == 0)) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tb/flash_tests.txt
# name op addr(hex) status(hex) exp_rd_data(hex) exp_wip_clear(hex) restart(dec)
# restart is the cycle offset of a second start pulse, 0 for none
read_zero      READ 000000 00 5A 0 0
read_ones      READ FFFFFF 00 A5 0 0
read_123456    READ 123456 00 2A 0 0
read_a5c3f0    READ A5C3F0 00 CC 0 0
read_00ff00    READ 00FF00 00 A5 0 0
read_800001    READ 800001 00 DB 0 0
read_5a5a5a    READ 5A5A5A 00 00 0 0
read_0f1e2d    READ 0F1E2D 00 66 0 0
rdsr_idle_00   RDSR 000000 00 00 1 0
rdsr_idle_02   RDSR 000000 02 02 1 0
rdsr_idle_7c   RDSR 000000 7C 7C 1 0
rdsr_busy_01   RDSR 000000 01 01 0 0
rdsr_busy_03   RDSR 000000 03 03 0 0
rdsr_busy_ff   RDSR 000000 FF FF 0 0
rdid_a         RDID 000000 00 EF 0 0
rdid_b         RDID ABCDEF 01 EF 0 0
restart_read_1 READ 123456 00 2A 0 1
restart_read_4 READ 0F1E2D 00 66 0 4
restart_rdsr_2 RDSR 000000 00 00 1 2
restart_rdid_6 RDID 000000 04 EF 0 6

// File: files.f
common/flash_pkg.sv
hw/flash_cmd_decode.sv
spi_engine/spi_shift_engine.sv
hw/flash_result.sv
hw/flash_ctrl_top.sv
tb/tb_clk_gen.sv
tb/spi_flash_model.sv
tb/tb_flash_ctrl.sv

// File: Bender.yml
package:
  name: spi_flash_ctrl

sources:
  - common/flash_pkg.sv
  - hw/flash_cmd_decode.sv
  - spi_engine/spi_shift_engine.sv
  - hw/flash_result.sv
  - hw/flash_ctrl_top.sv
  - target: simulation
    files:
      - tb/tb_clk_gen.sv
      - tb/spi_flash_model.sv
      - tb/tb_flash_ctrl.sv
